// File: sim/axi_sram_patterns.mem
// op_araddr_awaddr_wdata_strb_rresp_bresp, response codes 0 OKAY and 2 SLVERR
// op 1 read, 2 write, 3 read and write offered together, 4 AW before W, 5 W before AW

// plain write then read back
2_00000000_00000000_cafef00d_f_0_0
2_00000000_00000010_11223344_f_0_0
1_00000010_00000000_00000000_0_0_0
// partial strobes
2_00000000_00000020_a5a5a5a5_f_0_0
2_00000000_00000020_12345678_5_0_0
1_00000020_00000000_00000000_0_0_0
// out of range, word 0 must stay intact
2_00000000_00000400_deadbeef_f_0_2
1_00000400_00000000_00000000_0_2_0
1_00000000_00000000_00000000_0_0_0
// read wins, the write follows
3_00000010_00000030_0badf00d_f_0_0
1_00000030_00000000_00000000_0_0_0
// half writes held off until both channels are valid
4_00000000_00000040_87654321_f_0_0
5_00000000_00000044_13579bdf_f_0_0
2_00000000_00000044_ffee0000_c_0_0
1_00001000_00000000_00000000_0_2_0
3_00000044_00000800_55555555_f_0_2
1_00000040_00000000_00000000_0_0_0
1_00000000_00000000_00000000_0_0_0

// File: build.f
logic/axi_sram_pkg.sv
logic/axi_req_capture.sv
logic/sram_array.sv
logic/lfsr_delay.sv
logic/axi_resp_drive.sv
logic/axi_sram_top.sv
sim/axi_sram_checker.sv
sim/axi_sram_tb.sv

// File: Makefile
# Verilator build and run of the AXI SRAM slave testbench

VERILATOR ?= verilator
TOP       ?= axi_sram_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/axi_sram_tb.sv
// testbench top: clock, reset, pattern replay and master-side ready timing
`timescale 1ns/100ps
`default_nettype none

module axi_sram_tb;

	import axi_sram_pkg::*;

	localparam int DEPTH      = 256;
	localparam int CLK_PERIOD = 4;
	localparam int N_PAT      = 18;
	localparam int WAIT_LIMIT = 64;	// cycles per wait loop

	// one line of the pattern file
	typedef struct packed {
		logic [3:0] op;	// 1 read, 2 write, 3 both, 4 AW first, 5 W first
		addr_t      ar_addr;
		addr_t      aw_addr;
		data_t      wdata;
		strb_t      strb;
		logic [3:0] r_resp;
		logic [3:0] b_resp;
	} pattern_t;

	logic [$bits(pattern_t)-1:0] pat_mem [N_PAT];

	logic  clk;
	logic  rstn;
	addr_t ar_addr;
	logic  ar_valid;
	logic  ar_ready;
	addr_t aw_addr;
	logic  aw_valid;
	logic  aw_ready;
	data_t w_data;
	strb_t w_strb;
	logic  w_valid;
	logic  w_ready;
	data_t r_data;
	resp_t r_resp;
	logic  r_valid;
	logic  r_ready;
	resp_t b_resp;
	logic  b_valid;
	logic  b_ready;
	int    err_cnt;
	int    chk_cnt;
	int    timeouts;

	axi_sram_top #(
		.DEPTH      (DEPTH),
		.DELAY_MODE (DELAY_RANDOM),
		.LFSR_SEED  (4'd1)
	) axi_sram_top_inst (
		.clk        (clk),
		.rstn       (rstn),
		.ar_addr_i  (ar_addr),
		.ar_valid_i (ar_valid),
		.ar_ready_o (ar_ready),
		.aw_addr_i  (aw_addr),
		.aw_valid_i (aw_valid),
		.aw_ready_o (aw_ready),
		.w_data_i   (w_data),
		.w_strb_i   (w_strb),
		.w_valid_i  (w_valid),
		.w_ready_o  (w_ready),
		.r_data_o   (r_data),
		.r_resp_o   (r_resp),
		.r_valid_o  (r_valid),
		.r_ready_i  (r_ready),
		.b_resp_o   (b_resp),
		.b_valid_o  (b_valid),
		.b_ready_i  (b_ready)
	);

	axi_sram_checker #(
		.DEPTH (DEPTH)
	) checker_inst (
		.clk        (clk),
		.rstn       (rstn),
		.ar_addr_i  (ar_addr),
		.ar_valid_i (ar_valid),
		.ar_ready_i (ar_ready),
		.aw_addr_i  (aw_addr),
		.aw_valid_i (aw_valid),
		.aw_ready_i (aw_ready),
		.w_data_i   (w_data),
		.w_strb_i   (w_strb),
		.w_valid_i  (w_valid),
		.w_ready_i  (w_ready),
		.r_data_i   (r_data),
		.r_resp_i   (r_resp),
		.r_valid_i  (r_valid),
		.r_ready_i  (r_ready),
		.b_resp_i   (b_resp),
		.b_valid_i  (b_valid),
		.b_ready_i  (b_ready),
		.err_cnt_o  (err_cnt),
		.chk_cnt_o  (chk_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ready sampled mid-cycle and taken on the next rising edge
	task automatic wait_accept(input bit is_read);
		int n;
		bit ok;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
			ok = is_read ? ar_ready : (aw_ready && w_ready && !ar_valid);
		end
		if (!ok) begin
			$display("Timeout: the slave did not accept the %s request", is_read ? "read" : "write");
			timeouts++;
		end
		@(posedge clk);
		if (is_read) begin
			ar_valid <= 1'b0;
		end else begin
			aw_valid <= 1'b0;
			w_valid  <= 1'b0;
		end
	endtask

	// master back-pressure of 0 to 3 cycles once valid is up
	task automatic take_response(input bit is_write);
		int n;
		int stall;
		bit seen;
		n     = 0;
		seen  = 1'b0;
		stall = int'($urandom % 4);
		while (!seen && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
			seen = is_write ? b_valid : r_valid;
		end
		if (!seen) begin
			$display("Timeout: no %s response came from the slave", is_write ? "B" : "R");
			timeouts++;
		end else begin
			repeat (stall) @(posedge clk);
			@(posedge clk);
			r_ready <= !is_write;
			b_ready <= is_write;
			@(posedge clk);	// transfer edge
			r_ready <= 1'b0;
			b_ready <= 1'b0;
		end
	endtask

	task automatic run_pattern(input pattern_t p);
		bit do_rd;
		bit do_wr;
		do_rd = (p.op == 4'd1) || (p.op == 4'd3);
		do_wr = (p.op != 4'd1);
		if (do_rd)
			checker_inst.expect_response(1'b0, p.r_resp[1:0]);
		if (do_wr)
			checker_inst.expect_response(1'b1, p.b_resp[1:0]);
		@(posedge clk);
		if (do_rd) begin
			ar_addr  <= p.ar_addr;
			ar_valid <= 1'b1;
		end
		if (do_wr) begin
			aw_addr  <= p.aw_addr;
			w_data   <= p.wdata;
			w_strb   <= p.strb;
			aw_valid <= (p.op != 4'd5);
			w_valid  <= (p.op != 4'd4);
		end
		if (p.op == 4'd4 || p.op == 4'd5) begin
			repeat (3) @(posedge clk);	// half a write must not be taken
			aw_valid <= 1'b1;
			w_valid  <= 1'b1;
		end
		if (do_rd && timeouts == 0) begin
			wait_accept(1'b1);
			take_response(1'b0);
		end
		if (do_wr && timeouts == 0) begin
			wait_accept(1'b0);
			take_response(1'b1);
		end
	endtask

	initial begin
		int i;
		rstn     = 1'b0;
		ar_addr  = '0;
		ar_valid = 1'b0;
		aw_addr  = '0;
		aw_valid = 1'b0;
		w_data   = '0;
		w_strb   = '0;
		w_valid  = 1'b0;
		r_ready  = 1'b0;
		b_ready  = 1'b0;
		timeouts = 0;
		void'($urandom(16));
		$readmemh("sim/axi_sram_patterns.mem", pat_mem);
		repeat (4) @(posedge clk);
		rstn <= 1'b1;
		i = 0;
		while (i < N_PAT && timeouts == 0) begin
			run_pattern(pat_mem[i]);
			i++;
		end
		repeat (4) @(posedge clk);
		$display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, timeouts);
		if (err_cnt != 0 || timeouts != 0 || chk_cnt == 0)
			$display("TEST RESULT: FAIL");
		else
			$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/axi_sram_checker.sv
// testbench checker: reference memory, acceptance tracking, R/B compare and error counts
`timescale 1ns/100ps
`default_nettype none

module axi_sram_checker #(
	parameter int DEPTH = 256
) (
	input  wire                   clk,
	input  wire                   rstn,
	input  axi_sram_pkg::addr_t   ar_addr_i,
	input  wire                   ar_valid_i,
	input  wire                   ar_ready_i,
	input  axi_sram_pkg::addr_t   aw_addr_i,
	input  wire                   aw_valid_i,
	input  wire                   aw_ready_i,
	input  axi_sram_pkg::data_t   w_data_i,
	input  axi_sram_pkg::strb_t   w_strb_i,
	input  wire                   w_valid_i,
	input  wire                   w_ready_i,
	input  axi_sram_pkg::data_t   r_data_i,
	input  axi_sram_pkg::resp_t   r_resp_i,
	input  wire                   r_valid_i,
	input  wire                   r_ready_i,
	input  axi_sram_pkg::resp_t   b_resp_i,
	input  wire                   b_valid_i,
	input  wire                   b_ready_i,
	output int                    err_cnt_o,
	output int                    chk_cnt_o
);

	import axi_sram_pkg::*;

	data_t model [DEPTH];	// reference copy of the array
	resp_t r_exp_q [$];	// expected codes, filled by the testbench
	resp_t b_exp_q [$];
	logic  busy;	// one request in flight
	logic  flight_wr;
	addr_t flight_addr;
	logic  rd_acc;
	logic  wr_acc;
	logic  ready_was;
	logic  last_acc;
	logic  r_hold;	// R valid seen without ready
	logic  b_hold;
	data_t r_data_prev;
	resp_t r_resp_prev;
	resp_t b_resp_prev;

	function automatic logic in_range(input addr_t addr);
		return addr[ADDR_W-1:2] < DEPTH;
	endfunction

	task automatic expect_response(input logic is_write, input resp_t resp);
		if (is_write)
			b_exp_q.push_back(resp);
		else
			r_exp_q.push_back(resp);
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0d ns: %s", $time, msg);
		err_cnt_o++;
	endtask

	task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] want);
		chk_cnt_o++;
		if (got !== want)
			report_error($sformatf("%s is %h, expected %h", what, got, want));
	endtask

	always @(posedge clk) begin
		if (!rstn) begin
			busy      = 1'b0;
			ready_was = 1'b0;
			last_acc  = 1'b0;
			r_hold    = 1'b0;
			b_hold    = 1'b0;
			err_cnt_o = 0;
			chk_cnt_o = 0;
		end else begin
			// read wins and a write needs AW and W together
			rd_acc = ar_valid_i && ar_ready_i;
			wr_acc = !ar_valid_i && aw_valid_i && w_valid_i && aw_ready_i && w_ready_i;
			if (busy && (ar_ready_i || aw_ready_i || w_ready_i))
				report_error("ready high while a request is in flight");
			if (ready_was && !last_acc && !busy && !ar_ready_i)
				report_error("ready dropped without an acceptable request");
			if (!busy && (r_valid_i || b_valid_i))
				report_error("response valid with no request in flight");
			if (busy && (flight_wr ? r_valid_i : b_valid_i))
				report_error("response on the wrong channel");
			if (r_hold && !(r_valid_i && r_data_i === r_data_prev && r_resp_i === r_resp_prev))
				report_error("R valid or payload changed before the transfer");
			if (b_hold && !(b_valid_i && b_resp_i === b_resp_prev))
				report_error("B valid or response changed before the transfer");

			if (busy && !flight_wr && r_valid_i && r_ready_i) begin
				if (r_exp_q.size() == 0) begin
					report_error("R transfer with no expected response");
				end else begin
					check_equal("R resp", 32'(r_resp_i), 32'(r_exp_q.pop_front()));
					check_equal("R data", r_data_i,
						in_range(flight_addr) ? model[flight_addr[ADDR_W-1:2]] : data_t'(0));
				end
				busy = 1'b0;
			end
			if (busy && flight_wr && b_valid_i && b_ready_i) begin
				if (b_exp_q.size() == 0)
					report_error("B transfer with no expected response");
				else
					check_equal("B resp", 32'(b_resp_i), 32'(b_exp_q.pop_front()));
				busy = 1'b0;
			end

			if (rd_acc || wr_acc) begin
				busy        = 1'b1;
				flight_wr   = wr_acc;
				flight_addr = rd_acc ? ar_addr_i : aw_addr_i;
				if (wr_acc && in_range(aw_addr_i)) begin
					for (int b = 0; b < STRB_W; b++) begin
						if (w_strb_i[b])
							model[aw_addr_i[ADDR_W-1:2]][8*b +: 8] = w_data_i[8*b +: 8];
					end
				end
			end

			ready_was   = ar_ready_i;
			last_acc    = rd_acc || wr_acc;
			r_hold      = r_valid_i && !r_ready_i;
			b_hold      = b_valid_i && !b_ready_i;
			r_data_prev = r_data_i;
			r_resp_prev = r_resp_i;
			b_resp_prev = b_resp_i;
		end
	end

endmodule

`default_nettype wire

// File: logic/axi_sram_top.sv
// top level: AXI4-Lite style SRAM slave from capture, array, delay and response blocks
`timescale 1ns/100ps
`default_nettype none

module axi_sram_top #(
	parameter int                        DEPTH       = 256,
	parameter axi_sram_pkg::delay_mode_e DELAY_MODE  = axi_sram_pkg::DELAY_FIXED,
	parameter axi_sram_pkg::delay_t      FIXED_DELAY = 4'd2,
	parameter axi_sram_pkg::delay_t      LFSR_SEED   = 4'd1
) (
	input  wire                   clk,
	input  wire                   rstn,
	input  axi_sram_pkg::addr_t   ar_addr_i,
	input  wire                   ar_valid_i,
	output logic                  ar_ready_o,
	input  axi_sram_pkg::addr_t   aw_addr_i,
	input  wire                   aw_valid_i,
	output logic                  aw_ready_o,
	input  axi_sram_pkg::data_t   w_data_i,
	input  axi_sram_pkg::strb_t   w_strb_i,
	input  wire                   w_valid_i,
	output logic                  w_ready_o,
	output axi_sram_pkg::data_t   r_data_o,
	output axi_sram_pkg::resp_t   r_resp_o,
	output logic                  r_valid_o,
	input  wire                   r_ready_i,
	output axi_sram_pkg::resp_t   b_resp_o,
	output logic                  b_valid_o,
	input  wire                   b_ready_i
);

	import axi_sram_pkg::*;

	req_t     req;
	mem_rsp_t mem_rsp;
	delay_t   delay;
	logic     accept;
	logic     done;

	axi_req_capture req_capture_inst (
		.clk        (clk),
		.rstn       (rstn),
		.ar_addr_i  (ar_addr_i),
		.ar_valid_i (ar_valid_i),
		.aw_addr_i  (aw_addr_i),
		.aw_valid_i (aw_valid_i),
		.w_data_i   (w_data_i),
		.w_strb_i   (w_strb_i),
		.w_valid_i  (w_valid_i),
		.done_i     (done),
		.ar_ready_o (ar_ready_o),
		.aw_ready_o (aw_ready_o),
		.w_ready_o  (w_ready_o),
		.req_o      (req),
		.accept_o   (accept)
	);

	sram_array #(
		.DEPTH (DEPTH)
	) sram_array_inst (
		.clk      (clk),
		.rstn     (rstn),
		.accept_i (accept),
		.req_i    (req),
		.rsp_o    (mem_rsp)
	);

	lfsr_delay #(
		.DELAY_MODE  (DELAY_MODE),
		.FIXED_DELAY (FIXED_DELAY),
		.LFSR_SEED   (LFSR_SEED)
	) lfsr_delay_inst (
		.clk      (clk),
		.rstn     (rstn),
		.accept_i (accept),
		.delay_o  (delay)
	);

	axi_resp_drive resp_drive_inst (
		.clk        (clk),
		.rstn       (rstn),
		.accept_i   (accept),
		.is_write_i (req.is_write),
		.delay_i    (delay),
		.rsp_i      (mem_rsp),
		.r_ready_i  (r_ready_i),
		.b_ready_i  (b_ready_i),
		.r_data_o   (r_data_o),
		.r_resp_o   (r_resp_o),
		.r_valid_o  (r_valid_o),
		.b_resp_o   (b_resp_o),
		.b_valid_o  (b_valid_o),
		.done_o     (done)
	);

endmodule

`default_nettype wire

// File: logic/axi_resp_drive.sv
// response side: delay counter and R/B channel drive with done pulse
`timescale 1ns/100ps
`default_nettype none

module axi_resp_drive (
	input  wire                      clk,
	input  wire                      rstn,
	input  wire                      accept_i,
	input  wire                      is_write_i,
	input  axi_sram_pkg::delay_t     delay_i,
	input  axi_sram_pkg::mem_rsp_t   rsp_i,
	input  wire                      r_ready_i,
	input  wire                      b_ready_i,
	output axi_sram_pkg::data_t      r_data_o,
	output axi_sram_pkg::resp_t      r_resp_o,
	output logic                     r_valid_o,
	output axi_sram_pkg::resp_t      b_resp_o,
	output logic                     b_valid_o,
	output logic                     done_o
);

	import axi_sram_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WAIT,	// counting down the stretch
		RESP	// valid up, waiting for ready
	} state_e;

	state_e state_q;
	logic   is_wr_q;
	delay_t cnt_q;
	data_t  r_data_q;
	resp_t  r_resp_q;
	resp_t  b_resp_q;
	logic   r_valid_q;
	logic   b_valid_q;
	logic   done_q;
	logic   xfer;

	assign xfer = (r_valid_q && r_ready_i) || (b_valid_q && b_ready_i);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q   <= IDLE;
			is_wr_q   <= 1'b0;
			cnt_q     <= '0;
			r_data_q  <= '0;
			r_resp_q  <= RESP_OKAY;
			b_resp_q  <= RESP_OKAY;
			r_valid_q <= 1'b0;
			b_valid_q <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				IDLE: begin
					if (accept_i) begin
						is_wr_q <= is_write_i;
						cnt_q   <= delay_i;
						state_q <= WAIT;
					end
				end
				WAIT: begin
					if (cnt_q == '0) begin
						if (is_wr_q) begin
							b_resp_q  <= rsp_i.resp;
							b_valid_q <= 1'b1;
						end else begin
							r_data_q  <= rsp_i.rdata;
							r_resp_q  <= rsp_i.resp;
							r_valid_q <= 1'b1;
						end
						state_q <= RESP;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				RESP: begin
					if (xfer) begin
						r_valid_q <= 1'b0;
						b_valid_q <= 1'b0;
						done_q    <= 1'b1;	// frees the request side
						state_q   <= IDLE;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	assign r_data_o  = r_data_q;
	assign r_resp_o  = r_resp_q;
	assign r_valid_o = r_valid_q;
	assign b_resp_o  = b_resp_q;
	assign b_valid_o = b_valid_q;
	assign done_o    = done_q;

	a_one_valid: assert property (@(posedge clk) disable iff (!rstn)
		!(r_valid_o && b_valid_o))
		else $error("R and B valid together");

	// held under back-pressure with a stable payload
	a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
		r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o) && $stable(r_resp_o))
		else $error("R valid or payload dropped before transfer");

	a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
		b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
		else $error("B valid or response dropped before transfer");

endmodule

`default_nettype wire

// File: logic/lfsr_delay.sv
// response delay source: fixed value or 4-bit maximal LFSR
`timescale 1ns/100ps
`default_nettype none

module lfsr_delay #(
	parameter axi_sram_pkg::delay_mode_e DELAY_MODE  = axi_sram_pkg::DELAY_FIXED,
	parameter axi_sram_pkg::delay_t      FIXED_DELAY = 4'd2,
	parameter axi_sram_pkg::delay_t      LFSR_SEED   = 4'd1
) (
	input  wire                    clk,
	input  wire                    rstn,
	input  wire                    accept_i,
	output axi_sram_pkg::delay_t   delay_o
);

	import axi_sram_pkg::*;

	delay_t lfsr_q;

	// x^4 + x^3 + 1 runs through all 15 nonzero values
	always_ff @(posedge clk) begin
		if (!rstn)
			lfsr_q <= LFSR_SEED;
		else if (accept_i)
			lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};	// one step per request
	end

	assign delay_o = (DELAY_MODE == DELAY_RANDOM) ? lfsr_q : FIXED_DELAY;

	// a zero state would lock the lfsr up
	a_lfsr_nonzero: assert property (@(posedge clk) disable iff (!rstn)
		lfsr_q != '0)
		else $error("lfsr reached the all-zero state");

endmodule

`default_nettype wire

// File: logic/sram_array.sv
// word-addressed SRAM with byte strobes and out-of-range SLVERR
`timescale 1ns/100ps
`default_nettype none

module sram_array #(
	parameter int DEPTH = 256
) (
	input  wire                      clk,
	input  wire                      rstn,
	input  wire                      accept_i,
	input  axi_sram_pkg::req_t       req_i,
	output axi_sram_pkg::mem_rsp_t   rsp_o
);

	import axi_sram_pkg::*;

	localparam int WORD_W = ADDR_W - 2;
	localparam int IDX_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	data_t             mem_q [DEPTH];
	mem_rsp_t          rsp_q;
	logic [WORD_W-1:0] word_idx;
	logic [IDX_W-1:0]  mem_idx;
	logic              in_range;

	assign word_idx = req_i.addr[ADDR_W-1:2];	// byte address to word
	assign mem_idx  = word_idx[IDX_W-1:0];
	assign in_range = word_idx < WORD_W'(DEPTH);

	// only strobed bytes are written
	always_ff @(posedge clk) begin
		if (accept_i && req_i.is_write && in_range) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (req_i.strb[b])
					mem_q[mem_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
			end
		end
	end

	// answer stays until the next access
	always_ff @(posedge clk) begin
		if (!rstn) begin
			rsp_q <= '0;
		end else if (accept_i) begin
			if (!in_range)
				rsp_q <= '{rdata: '0, resp: RESP_SLVERR};	// nothing stored
			else if (req_i.is_write)
				rsp_q <= '{rdata: '0, resp: RESP_OKAY};
			else
				rsp_q <= '{rdata: mem_q[mem_idx], resp: RESP_OKAY};
		end
	end

	assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// File: logic/axi_req_capture.sv
// request capture: AR/AW/W acceptance FSM, read priority, request latch
`timescale 1ns/100ps
`default_nettype none

module axi_req_capture (
	input  wire                   clk,
	input  wire                   rstn,
	input  axi_sram_pkg::addr_t   ar_addr_i,
	input  wire                   ar_valid_i,
	input  axi_sram_pkg::addr_t   aw_addr_i,
	input  wire                   aw_valid_i,
	input  axi_sram_pkg::data_t   w_data_i,
	input  axi_sram_pkg::strb_t   w_strb_i,
	input  wire                   w_valid_i,
	input  wire                   done_i,
	output logic                  ar_ready_o,
	output logic                  aw_ready_o,
	output logic                  w_ready_o,
	output axi_sram_pkg::req_t    req_o,
	output logic                  accept_o
);

	import axi_sram_pkg::*;

	typedef enum logic {
		IDLE,
		BUSY
	} state_e;

	state_e state_q;
	logic   ready_q;	// low through reset and while busy
	logic   accept_q;
	logic   take_rd;
	logic   take_wr;
	req_t   req_q;

	// read wins when both are offered
	assign take_rd = (state_q == IDLE) && ready_q && ar_valid_i;
	assign take_wr = (state_q == IDLE) && ready_q && !ar_valid_i && aw_valid_i && w_valid_i;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q  <= IDLE;
			ready_q  <= 1'b0;
			accept_q <= 1'b0;
		end else begin
			accept_q <= take_rd || take_wr;
			case (state_q)
				IDLE: begin
					if (take_rd || take_wr) begin
						state_q <= BUSY;
						ready_q <= 1'b0;
					end else begin
						ready_q <= 1'b1;	// first idle cycle after reset
					end
				end
				BUSY: begin
					if (done_i) begin	// response has been taken
						state_q <= IDLE;
						ready_q <= 1'b1;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// request payload, held for the whole transaction
	always_ff @(posedge clk) begin
		if (take_rd || take_wr) begin
			req_q.is_write <= take_wr;
			req_q.addr     <= take_rd ? ar_addr_i : aw_addr_i;
			req_q.wdata    <= w_data_i;
			req_q.strb     <= w_strb_i;
		end
	end

	assign ar_ready_o = ready_q;
	assign aw_ready_o = ready_q;
	assign w_ready_o  = ready_q;
	assign req_o      = req_q;
	assign accept_o   = accept_q;

	a_no_ready_busy: assert property (@(posedge clk) disable iff (!rstn)
		state_q == BUSY |-> !(ar_ready_o || aw_ready_o || w_ready_o))
		else $error("ready raised while a transaction is in flight");

	// the pulse belongs to the edge that left idle
	a_accept_from_idle: assert property (@(posedge clk) disable iff (!rstn)
		accept_o |-> $past(state_q == IDLE) && state_q == BUSY)
		else $error("request accepted while busy");

endmodule

`default_nettype wire

// File: logic/axi_sram_pkg.sv
// widths, response codes, delay mode enum and request/response structs
`default_nettype none

package axi_sram_pkg;

	localparam int ADDR_W  = 32;
	localparam int DATA_W  = 32;
	localparam int STRB_W  = DATA_W / 8;	// one strobe bit per byte
	localparam int RESP_W  = 2;
	localparam int DELAY_W = 4;

	typedef logic [ADDR_W-1:0]  addr_t;	// byte address
	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [STRB_W-1:0]  strb_t;
	typedef logic [RESP_W-1:0]  resp_t;
	typedef logic [DELAY_W-1:0] delay_t;	// extra response latency in cycles

	// response codes as on the AXI bus
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// how the response stretch is chosen
	typedef enum logic {
		DELAY_FIXED,
		DELAY_RANDOM	// 4-bit lfsr value per request
	} delay_mode_e;

	// one accepted transaction, read or write
	typedef struct packed {
		logic  is_write;
		addr_t addr;
		data_t wdata;	// don't care on reads
		strb_t strb;
	} req_t;

	// memory answer to one access
	typedef struct packed {
		data_t rdata;	// zero on writes and errors
		resp_t resp;
	} mem_rsp_t;

endpackage

`default_nettype wire
